// ==== source/msx_pkg.sv ====
package msx_pkg;

   // memory geometry, sixteen 16 KB pages of on-chip RAM
   localparam int ram_addr_w     = 18;
   localparam int page_w         = 4;
   localparam int layout_entries = 64;
   localparam int lookup_entries = 16;
   localparam int apb_addr_w     = 8;

   // configuration map as seen from the APB port
   localparam logic [apb_addr_w-1:0] cfg_layout_base   = 8'h00;
   localparam logic [apb_addr_w-1:0] cfg_lookup_base   = 8'h40;
   localparam logic [apb_addr_w-1:0] cfg_expander_addr = 8'h80;
   localparam logic [apb_addr_w-1:0] cfg_load_addr     = 8'h81;
   localparam logic [apb_addr_w-1:0] cfg_load_data     = 8'h82;

   // CPU side register locations
   localparam logic [7:0]  slot_port     = 8'hA8;
   localparam logic [15:0] expander_addr = 16'hFFFF;

   typedef enum logic [1:0] {
      kind_none = 2'd0,
      kind_ram  = 2'd1,
      kind_rom  = 2'd2
   } block_kind_e;

   // one slot layout entry, indexed by slot, subslot and CPU page
   typedef struct packed {
      block_kind_e                   kind;
      logic [$clog2(lookup_entries)-1:0] ref_ram;
      logic [page_w-1:0]             page;
      logic [5:0]                    reserved;
   } block_t;

   // a RAM region, size counts pages so it needs one bit more than base
   typedef struct packed {
      logic [page_w-1:0] base;
      logic [page_w:0]   size;
      logic [6:0]        reserved;
   } lookup_ram_t;

   // the same 16-bit write word is a layout entry or a lookup entry by address
   typedef union packed {
      block_t      blk;
      lookup_ram_t ram;
   } cfg_word_u;

   typedef struct packed {
      logic        valid;
      logic        iorq;
      logic        wr;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } cpu_req_t;

   typedef struct packed {
      logic                  valid;
      logic                  wr;
      logic [ram_addr_w-1:0] addr;
      logic [7:0]            wdata;
   } ram_req_t;

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [apb_addr_w-1:0] paddr;
      logic [23:0]           pwdata;
   } apb_req_t;

endpackage

// ==== source/slot_select.sv ====
`timescale 1ns/100ps

// primary slot register at port A8h and the four secondary expander registers
module slot_select (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       primary_wr,
   input  logic       expander_wr,
   input  logic [7:0] wdata,
   input  logic [1:0] page,
   input  logic [3:0] expander_en,
   output logic [1:0] active_slot,
   output logic [1:0] active_subslot,
   output logic [7:0] primary_val,
   output logic [7:0] expander_val,
   output logic       page3_expanded
);

   logic [7:0] primary_reg;
   logic [7:0] secondary_reg [4];
   logic [1:0] page3_slot;

   // every CPU page owns a two-bit field, page 0 in the low bits
   assign active_slot = primary_reg[{page, 1'b0} +: 2];

   // the expander register lives at FFFFh, so the slot in page 3 owns it
   assign page3_slot     = primary_reg[7:6];
   assign page3_expanded = expander_en[page3_slot];

   always_comb begin
      if (expander_en[active_slot]) begin
         active_subslot = secondary_reg[active_slot][{page, 1'b0} +: 2];
      end else begin
         // a slot without expander behaves as subslot 0
         active_subslot = 2'b00;
      end
   end

   assign primary_val = primary_reg;

   // MSX expanders return the complement of the written value
   assign expander_val = ~secondary_reg[page3_slot];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         primary_reg <= 8'h00;
      end else if (primary_wr) begin
         primary_reg <= wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 4; i++) begin
            secondary_reg[i] <= 8'h00;
         end
      end else if (expander_wr) begin
         secondary_reg[page3_slot] <= wdata;
      end
   end

endmodule

// ==== source/layout_config.sv ====
`timescale 1ns/100ps

// APB slave holding the slot layout, the RAM lookup table and the loader window
module layout_config (
   input  logic                 clk,
   input  logic                 arst_n,
   input  msx_pkg::apb_req_t    apb,
   output logic [23:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   input  logic [5:0]           layout_id,
   output msx_pkg::block_t      block,
   output msx_pkg::lookup_ram_t lookup,
   output logic [3:0]           expander_en,
   output msx_pkg::ram_req_t    load_req,
   input  logic                 load_grant
);

   msx_pkg::block_t                layout_tab [msx_pkg::layout_entries];
   msx_pkg::lookup_ram_t           lookup_tab [msx_pkg::lookup_entries];
   logic [msx_pkg::ram_addr_w-1:0] load_addr;
   msx_pkg::cfg_word_u             cfg_word;
   logic                           access;
   logic                           reg_wr;
   logic                           hit_layout;
   logic                           hit_lookup;
   logic                           hit_expander;
   logic                           hit_load_addr;
   logic                           hit_load_data;
   logic                           hit_any;

   assign access = apb.psel && apb.penable;

   assign hit_layout    = apb.paddr[7:6] == msx_pkg::cfg_layout_base[7:6];
   assign hit_lookup    = apb.paddr[7:4] == msx_pkg::cfg_lookup_base[7:4];
   assign hit_expander  = apb.paddr == msx_pkg::cfg_expander_addr;
   assign hit_load_addr = apb.paddr == msx_pkg::cfg_load_addr;
   assign hit_load_data = apb.paddr == msx_pkg::cfg_load_data;
   assign hit_any = hit_layout || hit_lookup || hit_expander || hit_load_addr
                    || hit_load_data;

   // table words sit in the low 16 bits of pwdata
   assign cfg_word = apb.pwdata[15:0];

   // register writes finish in the first access cycle
   assign reg_wr = access && apb.pwrite && !hit_load_data;

   always_comb begin
      pready = 1'b0;
      if (access) begin
         if (apb.pwrite && hit_load_data) begin
            // a loader byte waits until the RAM port is free
            pready = load_grant;
         end else begin
            pready = 1'b1;
         end
      end
   end

   assign pslverr = access && !hit_any;

   always_comb begin
      prdata = '0;
      if (hit_layout) begin
         prdata[15:0] = layout_tab[apb.paddr[5:0]];
      end else if (hit_lookup) begin
         prdata[15:0] = lookup_tab[apb.paddr[3:0]];
      end else if (hit_expander) begin
         prdata[3:0] = expander_en;
      end else if (hit_load_addr) begin
         prdata[msx_pkg::ram_addr_w-1:0] = load_addr;
      end
   end

   // layout entries reset to kind none so nothing is mapped at start
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < msx_pkg::layout_entries; i++) begin
            layout_tab[i] <= '0;
         end
      end else if (reg_wr && hit_layout) begin
         layout_tab[apb.paddr[5:0]] <= cfg_word.blk;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_wr && hit_lookup) begin
         lookup_tab[apb.paddr[3:0]] <= cfg_word.ram;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         expander_en <= 4'b0000;
      end else if (reg_wr && hit_expander) begin
         expander_en <= apb.pwdata[3:0];
      end
   end

   // the address steps by one for every byte the arbiter accepts
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         load_addr <= '0;
      end else if (reg_wr && hit_load_addr) begin
         load_addr <= apb.pwdata[msx_pkg::ram_addr_w-1:0];
      end else if (load_grant) begin
         load_addr <= load_addr + 1'b1;
      end
   end

   always_comb begin
      load_req       = '0;
      load_req.valid = access && apb.pwrite && hit_load_data;
      load_req.wr    = 1'b1;
      load_req.addr  = load_addr;
      load_req.wdata = apb.pwdata[7:0];
   end

   assign block  = layout_tab[layout_id];
   assign lookup = lookup_tab[block.ref_ram];

endmodule

// ==== source/memory_router.sv ====
`timescale 1ns/100ps

// turns a CPU request into a slot register access or a block RAM access
module memory_router (
   input  logic                 clk,
   input  logic                 arst_n,
   input  msx_pkg::cpu_req_t    cpu,
   output logic                 ack,
   output logic [7:0]           rdata,
   output logic                 primary_wr,
   output logic                 expander_wr,
   output logic [7:0]           slot_wdata,
   output logic [1:0]           slot_page,
   input  logic [1:0]           active_slot,
   input  logic [1:0]           active_subslot,
   input  logic [7:0]           primary_val,
   input  logic [7:0]           expander_val,
   input  logic                 page3_expanded,
   output logic [5:0]           layout_id,
   input  msx_pkg::block_t      block,
   input  msx_pkg::lookup_ram_t lookup,
   output msx_pkg::ram_req_t    ram_req,
   input  logic [7:0]           ram_rdata,
   input  logic                 read_valid
);

   typedef enum logic [1:0] {
      st_idle,
      st_ram,
      st_ack
   } state_e;

   state_e                     state;
   logic                       start;
   logic                       slot_hit;
   logic                       exp_hit;
   logic                       mapped;
   logic                       rom_write;
   logic                       ram_hit;
   logic [msx_pkg::page_w-1:0] ram_page;
   logic [7:0]                 reg_rdata;

   // a request is taken once, in the idle state
   assign start = (state == st_idle) && cpu.valid;

   assign slot_hit = cpu.iorq && (cpu.addr[7:0] == msx_pkg::slot_port);
   assign exp_hit  = !cpu.iorq && (cpu.addr == msx_pkg::expander_addr) && page3_expanded;

   assign slot_page = cpu.addr[15:14];
   assign layout_id = {active_slot, active_subslot, cpu.addr[15:14]};

   // a page at or beyond the region size is treated as unmapped
   assign mapped = !cpu.iorq && (block.kind != msx_pkg::kind_none)
                   && ({1'b0, block.page} < lookup.size);
   assign rom_write = cpu.wr && (block.kind == msx_pkg::kind_rom);
   assign ram_hit   = mapped && !exp_hit && !rom_write;
   assign ram_page  = lookup.base + block.page;

   assign primary_wr  = start && slot_hit && cpu.wr;
   assign expander_wr = start && exp_hit && cpu.wr;
   assign slot_wdata  = cpu.wdata;

   always_comb begin
      ram_req       = '0;
      ram_req.valid = start && ram_hit;
      ram_req.wr    = cpu.wr;
      ram_req.addr  = {ram_page, cpu.addr[13:0]};
      ram_req.wdata = cpu.wdata;
   end

   // open bus reads as FFh
   always_comb begin
      if (slot_hit) begin
         reg_rdata = primary_val;
      end else if (exp_hit) begin
         reg_rdata = expander_val;
      end else begin
         reg_rdata = 8'hFF;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (cpu.valid) begin
                  state <= ram_hit ? st_ram : st_ack;
               end
            end
            st_ram: begin
               if (cpu.wr || read_valid) begin
                  state <= st_ack;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         rdata <= reg_rdata;
      end else if ((state == st_ram) && read_valid) begin
         rdata <= ram_rdata;
      end
   end

   assign ack = (state == st_ack);

endmodule

// ==== source/ram_arbiter.sv ====
`timescale 1ns/100ps

// fixed priority onto the block RAM, the CPU always wins over the loader
module ram_arbiter (
   input  logic              clk,
   input  logic              arst_n,
   input  msx_pkg::ram_req_t cpu_req,
   input  msx_pkg::ram_req_t load_req,
   output logic              load_grant,
   output logic              read_valid,
   output msx_pkg::ram_req_t mem_req
);

   assign load_grant = load_req.valid && !cpu_req.valid;

   always_comb begin
      if (cpu_req.valid) begin
         mem_req = cpu_req;
      end else begin
         // valid stays low here unless the loader is asking
         mem_req = load_req;
      end
   end

   // block RAM data shows up one cycle after a CPU read is issued
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         read_valid <= 1'b0;
      end else begin
         read_valid <= cpu_req.valid && !cpu_req.wr;
      end
   end

endmodule

// ==== source/block_ram.sv ====
`timescale 1ns/100ps

// single port byte RAM with registered read data
module block_ram (
   input  logic              clk,
   input  msx_pkg::ram_req_t mem_req,
   output logic [7:0]        rdata
);

   logic [7:0] mem [2**msx_pkg::ram_addr_w];

   always_ff @(posedge clk) begin
      if (mem_req.valid) begin
         if (mem_req.wr) begin
            mem[mem_req.addr] <= mem_req.wdata;
         end else begin
            rdata <= mem[mem_req.addr];
         end
      end
   end

endmodule

// ==== source/msx_memory_subsystem.sv ====
`timescale 1ns/100ps

// memory side of the slot system, CPU port and APB configuration port
module msx_memory_subsystem (
   input  logic              clk,
   input  logic              arst_n,
   input  msx_pkg::cpu_req_t cpu,
   output logic              ack,
   output logic [7:0]        rdata,
   input  msx_pkg::apb_req_t apb,
   output logic [23:0]       prdata,
   output logic              pready,
   output logic              pslverr
);

   logic                 primary_wr;
   logic                 expander_wr;
   logic [7:0]           slot_wdata;
   logic [1:0]           slot_page;
   logic [3:0]           expander_en;
   logic [1:0]           active_slot;
   logic [1:0]           active_subslot;
   logic [7:0]           primary_val;
   logic [7:0]           expander_val;
   logic                 page3_expanded;
   logic [5:0]           layout_id;
   msx_pkg::block_t      block;
   msx_pkg::lookup_ram_t lookup;
   msx_pkg::ram_req_t    cpu_ram_req;
   msx_pkg::ram_req_t    load_req;
   msx_pkg::ram_req_t    mem_req;
   logic                 load_grant;
   logic                 read_valid;
   logic [7:0]           ram_rdata;

   slot_select slot_select (
      .clk            (clk),
      .arst_n         (arst_n),
      .primary_wr     (primary_wr),
      .expander_wr    (expander_wr),
      .wdata          (slot_wdata),
      .page           (slot_page),
      .expander_en    (expander_en),
      .active_slot    (active_slot),
      .active_subslot (active_subslot),
      .primary_val    (primary_val),
      .expander_val   (expander_val),
      .page3_expanded (page3_expanded)
   );

   layout_config layout_config (
      .clk         (clk),
      .arst_n      (arst_n),
      .apb         (apb),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .layout_id   (layout_id),
      .block       (block),
      .lookup      (lookup),
      .expander_en (expander_en),
      .load_req    (load_req),
      .load_grant  (load_grant)
   );

   memory_router memory_router (
      .clk            (clk),
      .arst_n         (arst_n),
      .cpu            (cpu),
      .ack            (ack),
      .rdata          (rdata),
      .primary_wr     (primary_wr),
      .expander_wr    (expander_wr),
      .slot_wdata     (slot_wdata),
      .slot_page      (slot_page),
      .active_slot    (active_slot),
      .active_subslot (active_subslot),
      .primary_val    (primary_val),
      .expander_val   (expander_val),
      .page3_expanded (page3_expanded),
      .layout_id      (layout_id),
      .block          (block),
      .lookup         (lookup),
      .ram_req        (cpu_ram_req),
      .ram_rdata      (ram_rdata),
      .read_valid     (read_valid)
   );

   ram_arbiter ram_arbiter (
      .clk        (clk),
      .arst_n     (arst_n),
      .cpu_req    (cpu_ram_req),
      .load_req   (load_req),
      .load_grant (load_grant),
      .read_valid (read_valid),
      .mem_req    (mem_req)
   );

   block_ram block_ram (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (ram_rdata)
   );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

// free running clock, reset released on a falling edge after the reset cycles
module tb_clock #(
   parameter int period       = 10,
   parameter int reset_cycles = 10
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

// ==== tests/msx_memory_props.sv ====
`timescale 1ns/100ps

// protocol properties of the CPU port and the RAM request of memory_router
module msx_memory_props (
   input logic                 clk,
   input logic                 arst_n,
   input msx_pkg::cpu_req_t    cpu,
   input logic                 start,
   input logic                 ack,
   input msx_pkg::ram_req_t    ram_req,
   input msx_pkg::block_t      block
);

   int failures = 0;

   // the master keeps the request steady until the ack cycle
   cpu_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (cpu.valid && !ack) |=> $stable(cpu))
      else begin
         $error("cpu request changed before ack");
         failures++;
      end

   ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      ack |=> !ack)
      else begin
         $error("ack held longer than one cycle");
         failures++;
      end

   // a ROM write never reaches the RAM and is acknowledged on the next cycle
   no_rom_write: assert property (@(posedge clk) disable iff (!arst_n)
      (start && !cpu.iorq && cpu.wr && (block.kind == msx_pkg::kind_rom))
      |-> !ram_req.valid ##1 ack)
      else begin
         $error("ROM write reached the RAM or was not acknowledged in one cycle");
         failures++;
      end

endmodule

bind memory_router msx_memory_props props0 (
   .clk     (clk),
   .arst_n  (arst_n),
   .cpu     (cpu),
   .start   (start),
   .ack     (ack),
   .ram_req (ram_req),
   .block   (block)
);

// ==== tests/tb_msx_memory.sv ====
`timescale 1ns/100ps

module tb_msx_memory;

   typedef enum logic [2:0] {
      op_apb_wr, op_apb_rd, op_load, op_io_wr, op_mem_wr, op_rd_mem, op_rd_io, op_contend
   } op_e;

   typedef struct packed {
      op_e         kind;
      logic [15:0] addr;
      logic [23:0] wdata;
      logic [31:0] exp;
      logic [31:0] burst;
   } row_t;

   logic              clk;
   logic              arst_n;
   msx_pkg::cpu_req_t cpu;
   logic              ack;
   logic [7:0]        rdata;
   msx_pkg::apb_req_t apb;
   logic [23:0]       prdata;
   logic              pready;
   logic              pslverr;

   row_t        tab[$];
   int unsigned seed = 34;
   int          cycles = 0;
   int          limit = 1000000;
   int          errors = 0;

   // reference model state
   logic [15:0] m_layout [64];
   logic [15:0] m_lookup [16];
   logic [3:0]  m_exp_en;
   logic [7:0]  m_primary;
   logic [7:0]  m_secondary [4];
   logic [17:0] m_load_addr;
   logic [7:0]  ram_img [int];

   tb_clock clock0 (.clk(clk), .arst_n(arst_n));

   msx_memory_subsystem dut0 (
      .clk     (clk),
      .arst_n  (arst_n),
      .cpu     (cpu),
      .ack     (ack),
      .rdata   (rdata),
      .apb     (apb),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout: the DUT did not finish a transfer within %0d cycles", limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function automatic logic [7:0] next_byte();
      seed = seed * 1103515245 + 12345;
      return seed[23:16];
   endfunction

   function automatic logic [15:0] blk(input logic [1:0] kind, input logic [3:0] ref_ram,
                                       input logic [3:0] page);
      return {kind, ref_ram, page, 6'b0};
   endfunction

   function automatic logic [15:0] lk(input logic [3:0] base, input logic [4:0] size);
      return {base, size, 7'b0};
   endfunction

   // returns the block kind in the top two bits and the RAM address below it
   // a zero kind stands for an unmapped page or a page beyond its region
   function automatic logic [19:0] decode(input logic [15:0] addr);
      logic [1:0]  pg;
      logic [1:0]  slot;
      logic [1:0]  sub;
      logic [15:0] b;
      logic [15:0] l;
      pg = addr[15:14];
      slot = m_primary[2 * pg +: 2];
      sub = m_exp_en[slot] ? m_secondary[slot][2 * pg +: 2] : 2'b00;
      b = m_layout[{slot, sub, pg}];
      l = m_lookup[b[13:10]];
      if (b[15:14] == 2'd0 || {1'b0, b[9:6]} >= l[11:7]) begin
         return '0;
      end
      return {b[15:14], l[15:12] + b[9:6], addr[13:0]};
   endfunction

   function automatic logic [7:0] model_read(input logic iorq, input logic [15:0] addr);
      logic [19:0] d;
      if (iorq) begin
         return (addr[7:0] == 8'hA8) ? m_primary : 8'hFF;
      end
      if (addr == 16'hFFFF && m_exp_en[m_primary[7:6]]) begin
         return ~m_secondary[m_primary[7:6]];
      end
      d = decode(addr);
      return (d[19:18] == 2'd0) ? 8'hFF : ram_img[d[17:0]];
   endfunction

   // appends one row and advances the model so that the row carries its expected value
   task automatic add(input op_e kind, input logic [15:0] addr, input logic [23:0] wdata);
      row_t        r;
      logic [19:0] d;
      r = '0;
      r.kind = kind;
      r.addr = addr;
      r.wdata = wdata;
      case (kind)
         op_apb_wr: begin
            if (addr < 16'h40) m_layout[addr[5:0]] = wdata[15:0];
            else if (addr < 16'h50) m_lookup[addr[3:0]] = wdata[15:0];
            else if (addr == 16'h80) m_exp_en = wdata[3:0];
            else if (addr == 16'h81) m_load_addr = wdata[17:0];
            else r.exp[24] = 1'b1;
         end
         op_apb_rd: begin
            if (addr < 16'h40) r.exp = m_layout[addr[5:0]];
            else if (addr < 16'h50) r.exp = m_lookup[addr[3:0]];
            else if (addr == 16'h80) r.exp = m_exp_en;
            else if (addr == 16'h81) r.exp = m_load_addr;
            else r.exp = 32'h0100_0000;
         end
         op_load: begin
            ram_img[m_load_addr] = wdata[7:0];
            m_load_addr++;
         end
         op_io_wr: begin
            if (addr[7:0] == 8'hA8) m_primary = wdata[7:0];
         end
         op_mem_wr: begin
            d = decode(addr);
            if (addr == 16'hFFFF && m_exp_en[m_primary[7:6]]) begin
               m_secondary[m_primary[7:6]] = wdata[7:0];
            end else if (d[19:18] == 2'd1) begin
               ram_img[d[17:0]] = wdata[7:0];
            end
         end
         op_rd_mem: r.exp = model_read(1'b0, addr);
         op_rd_io: r.exp = model_read(1'b1, addr);
         op_contend: begin
            r.exp = model_read(1'b0, addr);
            for (int k = 0; k < 4; k++) begin
               r.burst[8 * k +: 8] = next_byte();
               ram_img[m_load_addr] = r.burst[8 * k +: 8];
               m_load_addr++;
            end
         end
         default: ;
      endcase
      tab.push_back(r);
   endtask

   task automatic load_run(input logic [17:0] addr, input int n);
      add(op_apb_wr, 16'h81, addr);
      repeat (n) add(op_load, 16'h0, next_byte());
   endtask

   task automatic build_table();
      add(op_apb_wr, 16'h40, lk(4'd0, 5'd4));
      add(op_apb_wr, 16'h41, lk(4'd4, 5'd2));
      add(op_apb_wr, 16'h42, lk(4'd8, 5'd1));
      add(op_apb_wr, 16'd0, blk(2'd2, 4'd2, 4'd0));
      add(op_apb_wr, 16'd1, blk(2'd1, 4'd0, 4'd1));
      add(op_apb_wr, 16'd2, blk(2'd1, 4'd1, 4'd3));
      add(op_apb_wr, 16'd17, blk(2'd1, 4'd1, 4'd0));
      add(op_apb_wr, 16'd33, blk(2'd1, 4'd0, 4'd2));
      add(op_apb_wr, 16'd37, blk(2'd1, 4'd1, 4'd1));
      add(op_apb_rd, 16'd0, 0);
      add(op_apb_rd, 16'h41, 0);
      add(op_apb_rd, 16'd37, 0);
      add(op_apb_rd, 16'h90, 0);
      load_run(18'h20000, 4);
      add(op_apb_rd, 16'h81, 0);
      load_run(18'h04010, 1);
      load_run(18'h10010, 1);
      load_run(18'h08010, 1);
      load_run(18'h14010, 1);
      for (int a = 0; a < 4; a++) add(op_rd_mem, a, 0);
      // the ROM keeps its data and pages out of range or empty read open bus
      add(op_mem_wr, 16'h0001, next_byte());
      add(op_rd_mem, 16'h0001, 0);
      add(op_rd_mem, 16'h8000, 0);
      add(op_rd_mem, 16'hC000, 0);
      add(op_rd_mem, 16'h4010, 0);
      add(op_io_wr, 16'h00A8, 8'h04);
      add(op_rd_io, 16'h00A8, 0);
      add(op_rd_mem, 16'h4010, 0);
      add(op_mem_wr, 16'h4020, next_byte());
      add(op_rd_mem, 16'h4020, 0);
      // slot 2 becomes expanded and sits in pages 1 and 3
      add(op_apb_wr, 16'h80, 24'h4);
      add(op_apb_rd, 16'h80, 0);
      add(op_io_wr, 16'h00A8, 8'h88);
      add(op_rd_mem, 16'h4010, 0);
      add(op_mem_wr, 16'hFFFF, 8'h04);
      add(op_rd_mem, 16'hFFFF, 0);
      add(op_rd_mem, 16'h4010, 0);
      add(op_apb_wr, 16'h81, 18'h14100);
      add(op_contend, 16'h4010, 0);
      for (int a = 0; a < 4; a++) add(op_rd_mem, 16'h4100 + a, 0);
   endtask

   // starts and ends on a falling edge and samples pready just before the rising edge
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [23:0] wdata,
                           output logic [23:0] rd, output logic err);
      apb = '0;
      apb.psel = 1'b1;
      apb.pwrite = wr;
      apb.paddr = addr;
      apb.pwdata = wdata;
      @(negedge clk);
      apb.penable = 1'b1;
      forever begin
         #4;
         if (pready) break;
         @(negedge clk);
      end
      rd = prdata;
      err = pslverr;
      @(negedge clk);
      apb = '0;
   endtask

   task automatic cpu_xfer(input logic iorq, input logic wr, input logic [15:0] addr,
                           input logic [7:0] wdata, output logic [7:0] rd);
      cpu.valid = 1'b1;
      cpu.iorq = iorq;
      cpu.wr = wr;
      cpu.addr = addr;
      cpu.wdata = wdata;
      forever begin
         #4;
         if (ack) break;
         @(negedge clk);
      end
      rd = rdata;
      @(negedge clk);
      cpu = '0;
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what,
                        inout logic ok);
      assert (got === exp) else begin
         $display("FAIL %0t %s: got %h expected %h", $time, what, got, exp);
         ok = 1'b0;
      end
   endtask

   task automatic run_op(input row_t r, output logic ok);
      logic [23:0] rd;
      logic        err;
      logic [7:0]  cd;
      logic [7:0]  cd2;
      ok = 1'b1;
      case (r.kind)
         op_apb_wr: begin
            apb_xfer(1'b1, r.addr[7:0], r.wdata, rd, err);
            check(err, r.exp[24], "apb write pslverr", ok);
         end
         op_apb_rd: begin
            apb_xfer(1'b0, r.addr[7:0], 24'h0, rd, err);
            check({err, rd}, r.exp, "apb readback", ok);
         end
         op_load: begin
            apb_xfer(1'b1, msx_pkg::cfg_load_data, r.wdata, rd, err);
            check(err, 0, "loader write pslverr", ok);
         end
         op_io_wr: cpu_xfer(1'b1, 1'b1, r.addr, r.wdata[7:0], cd);
         op_mem_wr: cpu_xfer(1'b0, 1'b1, r.addr, r.wdata[7:0], cd);
         op_rd_mem: begin
            cpu_xfer(1'b0, 1'b0, r.addr, 8'h0, cd);
            check(cd, r.exp, "cpu memory read", ok);
         end
         op_rd_io: begin
            cpu_xfer(1'b1, 1'b0, r.addr, 8'h0, cd);
            check(cd, r.exp, "cpu io read", ok);
         end
         op_contend: begin
            fork
               begin
                  for (int k = 0; k < 4; k++) begin
                     apb_xfer(1'b1, msx_pkg::cfg_load_data, r.burst[8 * k +: 8], rd, err);
                     check(err, 0, "loader burst pslverr", ok);
                  end
               end
               begin
                  // one cycle late so the read lands on a loader access cycle
                  @(negedge clk);
                  cpu_xfer(1'b0, 1'b0, r.addr, 8'h0, cd2);
                  check(cd2, r.exp, "cpu read under loader traffic", ok);
               end
            join
         end
         default: ;
      endcase
   endtask

   initial begin
      logic ok;
      int   prop_fails;
      cpu = '0;
      apb = '0;
      m_exp_en = '0;
      m_primary = '0;
      m_load_addr = '0;
      for (int i = 0; i < 64; i++) m_layout[i] = '0;
      for (int i = 0; i < 16; i++) m_lookup[i] = '0;
      for (int i = 0; i < 4; i++) m_secondary[i] = '0;
      build_table();
      // each row may take as long as the slowest one which is a loader burst under a CPU read
      limit = 20 + tab.size() * 40 + 100;
      @(posedge arst_n);
      @(negedge clk);
      foreach (tab[i]) begin
         run_op(tab[i], ok);
         if (!ok) errors++;
         $display("test %0d %s %s", i, tab[i].kind.name(), ok ? "ok" : "error");
      end
      prop_fails = dut0.memory_router.props0.failures;
      $display("%0d tests run, %0d failed, %0d assertion failures", tab.size(), errors,
               prop_fails);
      if (errors == 0 && prop_fails == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
source/msx_pkg.sv
source/slot_select.sv
source/layout_config.sv
source/memory_router.sv
source/ram_arbiter.sv
source/block_ram.sv
source/msx_memory_subsystem.sv
tests/tb_clock.sv
tests/msx_memory_props.sv
tests/tb_msx_memory.sv
